//--- src/icache_pkg.sv
package icache_pkg;

    // address split from the high bits down
    localparam int tag_bits    = 20;
    localparam int index_bits  = 8;
    localparam int offset_bits = 4;

    localparam int num_sets   = 256;
    localparam int line_words = 4;
    localparam int word_bits  = $clog2(line_words);

    localparam logic [2:0] rd_type_line = 3'b100;  // full line read

    typedef logic [line_words-1:0][31:0] line_t;

    // raw view for front end and memory, field view for the lookup
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]              tag;
            logic [index_bits-1:0]            index;
            logic [word_bits-1:0]             word_sel;
            logic [offset_bits-word_bits-1:0] byte_sel;
        } fields;
    } icache_addr_u;

    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } front_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic        cache_miss;
        logic [31:0] rdata;
    } front_resp_t;

    typedef struct packed {
        logic        rd_req;
        logic [2:0]  rd_type;
        logic [31:0] rd_addr;
    } mem_req_t;

    typedef struct packed {
        logic        rd_rdy;
        logic        ret_valid;
        logic        ret_last;
        logic [31:0] ret_data;
    } mem_resp_t;

    typedef struct packed {
        logic  hit;
        line_t line;
    } way_result_t;

    typedef struct packed {
        logic idle;
        logic last_hit;
    } cache_status_t;

endpackage

//--- src/icache_way.sv
module icache_way (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [icache_pkg::index_bits-1:0] lookup_index,
    input  logic [icache_pkg::tag_bits-1:0]   lookup_tag,
    input  logic                              lookup_en,
    input  logic                              write_en,
    input  logic [icache_pkg::index_bits-1:0] write_index,
    input  logic [icache_pkg::tag_bits-1:0]   write_tag,
    input  icache_pkg::line_t                 write_line,
    output icache_pkg::way_result_t           result
);
    import icache_pkg::*;

    logic [tag_bits-1:0] tag_mem [num_sets];
    line_t               data_mem [num_sets];
    logic [num_sets-1:0] valid_bits;

    logic [tag_bits-1:0] rd_tag;    // tag of the set being looked up
    line_t               rd_line;
    logic                rd_valid;

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[write_index]  <= write_tag;
            data_mem[write_index] <= write_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            valid_bits <= '0;
        else if (write_en)
            valid_bits[write_index] <= 1'b1;
    end

    // set read, one cycle ahead of the compare
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_tag  <= tag_mem[lookup_index];
            rd_line <= data_mem[lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            rd_valid <= 1'b0;
        else if (lookup_en)
            rd_valid <= valid_bits[lookup_index];
    end

    // lookup_tag is the tag of the accepted request
    assign result.hit  = rd_valid && (rd_tag == lookup_tag);
    assign result.line = rd_line;

endmodule

//--- src/icache_refill.sv
module icache_refill (
    input  logic                  clk,
    input  logic                  reset,
    input  icache_pkg::mem_resp_t mem,
    output icache_pkg::line_t     line,
    output logic                  line_done
);
    import icache_pkg::*;

    logic [word_bits-1:0] beat_cnt;   // next word to fill
    line_t                line_buf;

    always_ff @(posedge clk) begin
        if (reset)
            beat_cnt <= '0;
        else if (mem.ret_valid) begin
            if (mem.ret_last)
                beat_cnt <= '0;
            else
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.ret_valid)
            line_buf[beat_cnt] <= mem.ret_data;
    end

    // last beat goes straight through so the line is whole on the ret_last edge
    always_comb begin
        line = line_buf;
        if (mem.ret_valid)
            line[beat_cnt] = mem.ret_data;
    end

    assign line_done = mem.ret_valid && mem.ret_last;

endmodule

//--- src/icache_ctrl.sv
module icache_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  icache_pkg::front_req_t            req,
    input  icache_pkg::way_result_t           way0,
    input  icache_pkg::way_result_t           way1,
    input  icache_pkg::line_t                 line,
    input  logic                              line_done,
    input  logic                              rd_rdy,
    output icache_pkg::front_resp_t           resp,
    output icache_pkg::mem_req_t              mem_req,
    output logic [icache_pkg::index_bits-1:0] lookup_index,
    output logic [icache_pkg::tag_bits-1:0]   lookup_tag,
    output logic                              lookup_en,
    output logic                              write_en0,
    output logic                              write_en1,
    output icache_pkg::cache_status_t         status
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_ask_mem,
        st_refill
    } state_t;

    state_t              state;
    state_t              next_state;
    icache_addr_u        cur_addr;    // accepted request
    logic [num_sets-1:0] lru;         // way to replace next, per set
    logic                hit;
    logic                addr_ok;
    logic                lookup_hit;
    logic                fill_done;
    logic                victim;
    logic                data_ok_q;
    logic [31:0]         rdata_q;
    logic                last_hit_q;

    assign hit        = way0.hit | way1.hit;
    assign lookup_hit = (state == st_lookup) && hit;
    assign fill_done  = (state == st_refill) && line_done;
    assign victim     = lru[cur_addr.fields.index];

    // a hit frees the lookup stage for the next request
    assign addr_ok = req.valid && (state == st_idle || lookup_hit);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req.valid)
                    next_state = st_lookup;
            end
            st_lookup: begin
                if (!hit)
                    next_state = st_ask_mem;
                else if (!req.valid)
                    next_state = st_idle;   // stays in lookup when a new request follows
            end
            st_ask_mem: begin
                if (rd_rdy)
                    next_state = st_refill;
            end
            st_refill: begin
                if (line_done)
                    next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (addr_ok)
            cur_addr <= req.addr;
    end

    always_ff @(posedge clk) begin
        if (reset)
            lru <= '0;
        else if (lookup_hit)
            lru[cur_addr.fields.index] <= way0.hit;   // replace the other way next
        else if (fill_done)
            lru[cur_addr.fields.index] <= ~victim;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok_q  <= 1'b0;
            last_hit_q <= 1'b0;
        end else begin
            data_ok_q <= lookup_hit || fill_done;
            if (state == st_lookup)
                last_hit_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit)
            rdata_q <= way0.hit ? way0.line[cur_addr.fields.word_sel]
                                : way1.line[cur_addr.fields.word_sel];
        else if (fill_done)
            rdata_q <= line[cur_addr.fields.word_sel];   // word from the fresh line
    end

    // refill writes go to the held set, lookups use the incoming address
    assign lookup_index = (state == st_refill) ? cur_addr.fields.index
                                               : req.addr.fields.index;
    assign lookup_tag   = cur_addr.fields.tag;
    assign lookup_en    = addr_ok;
    assign write_en0    = fill_done && !victim;
    assign write_en1    = fill_done && victim;

    assign resp.addr_ok    = addr_ok;
    assign resp.data_ok    = data_ok_q;
    assign resp.cache_miss = (state == st_lookup) && !hit;
    assign resp.rdata      = rdata_q;

    assign mem_req.rd_req  = (state == st_ask_mem);
    assign mem_req.rd_type = rd_type_line;
    assign mem_req.rd_addr = {cur_addr.raw[31:offset_bits], {offset_bits{1'b0}}};

    assign status.idle     = (state == st_idle);
    assign status.last_hit = last_hit_q;

endmodule

//--- src/icache_top.sv
module icache_top (
    input  logic                      clk,
    input  logic                      reset,
    input  icache_pkg::front_req_t    req,
    input  icache_pkg::mem_resp_t     mem_resp,
    output icache_pkg::front_resp_t   resp,
    output icache_pkg::mem_req_t      mem_req,
    output icache_pkg::cache_status_t status
);
    import icache_pkg::*;

    logic [index_bits-1:0] lookup_index;   // also the write index during refill
    logic [tag_bits-1:0]   lookup_tag;
    logic                  lookup_en;
    logic                  write_en0;
    logic                  write_en1;
    way_result_t           way0_res;
    way_result_t           way1_res;
    line_t                 fill_line;
    logic                  line_done;

    icache_way way0 (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_en    (lookup_en),
        .write_en     (write_en0),
        .write_index  (lookup_index),
        .write_tag    (lookup_tag),
        .write_line   (fill_line),
        .result       (way0_res)
    );

    icache_way way1 (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_en    (lookup_en),
        .write_en     (write_en1),
        .write_index  (lookup_index),
        .write_tag    (lookup_tag),
        .write_line   (fill_line),
        .result       (way1_res)
    );

    icache_refill refill (
        .clk       (clk),
        .reset     (reset),
        .mem       (mem_resp),
        .line      (fill_line),
        .line_done (line_done)
    );

    icache_ctrl ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .way0         (way0_res),
        .way1         (way1_res),
        .line         (fill_line),
        .line_done    (line_done),
        .rd_rdy       (mem_resp.rd_rdy),
        .resp         (resp),
        .mem_req      (mem_req),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_en    (lookup_en),
        .write_en0    (write_en0),
        .write_en1    (write_en1),
        .status       (status)
    );

endmodule

//--- testbench/icache_asserts.sv
module icache_asserts (
    input logic                    clk,
    input logic                    reset,
    input icache_pkg::front_req_t  req,
    input icache_pkg::front_resp_t resp,
    input icache_pkg::mem_req_t    mem_req,
    input icache_pkg::mem_resp_t   mem_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    // read request held until memory takes it
    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req.rd_req && !mem_resp.rd_rdy |=> mem_req.rd_req && $stable(mem_req.rd_addr))
        else $error("rd_req dropped or rd_addr changed before rd_rdy");

    // no new request while a line read is in flight
    addr_ok_when_free: assert property (@(posedge clk) disable iff (reset)
        resp.addr_ok |-> req.valid && !mem_req.rd_req && !mem_resp.ret_valid)
        else $error("addr_ok high without valid or while a line read is pending");

    // second answer in a row needs an accept two cycles back
    data_ok_single: assert property (@(posedge clk) disable iff (reset)
        resp.data_ok |=> !resp.data_ok || $past(req.valid && resp.addr_ok, 2))
        else $error("data_ok high twice without a new request");

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !mem_req.rd_req && !resp.data_ok)
        else $error("rd_req or data_ok high right after reset");

endmodule

bind icache_top icache_asserts asserts (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .resp     (resp),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
);

//--- testbench/icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    localparam logic [31:0] mem_key = 32'h3c5a_9e17;   // memory contents pattern
    localparam int          wait_limit = 200;

    logic          clk;
    logic          reset;
    front_req_t    req;
    mem_resp_t     mem_resp = '0;
    front_resp_t   resp;
    mem_req_t      mem_req;
    cache_status_t status;

    int   errors = 0;
    logic finished = 1'b0;

    // reference copy of the tag store
    logic [tag_bits-1:0] model_tag [2][num_sets];
    logic                model_valid [2][num_sets];
    logic                model_lru [num_sets];

    int          resp_delay;
    logic [31:0] resp_line;
    int          beat;

    icache_top uut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .mem_resp (mem_resp),
        .resp     (resp),
        .mem_req  (mem_req),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ mem_key;
    endfunction

    // memory responder serving one line read at a time
    always begin
        @(negedge clk);
        if (!reset && mem_req.rd_req) begin
            resp_delay = $urandom_range(5, 0);
            resp_line  = mem_req.rd_addr;
            repeat (resp_delay) @(negedge clk);
            mem_resp.rd_rdy = 1'b1;
            @(negedge clk);
            mem_resp.rd_rdy = 1'b0;
            for (beat = 0; beat < 4; beat++) begin
                mem_resp.ret_valid = 1'b1;
                mem_resp.ret_last  = (beat == 3);
                mem_resp.ret_data  = mem_word(resp_line + 32'(4 * beat));
                @(negedge clk);
            end
            mem_resp.ret_valid = 1'b0;
            mem_resp.ret_last  = 1'b0;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_model();
        int s;
        for (s = 0; s < num_sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
    endtask

    // way that holds the address or -1 on a miss
    function automatic int model_way(input logic [31:0] addr);
        icache_addr_u a;
        int           w;
        a.raw = addr;
        for (w = 0; w < 2; w++) begin
            if (model_valid[w][a.fields.index] && model_tag[w][a.fields.index] == a.fields.tag)
                return w;
        end
        return -1;
    endfunction

    task automatic model_update(input logic [31:0] addr, input int way);
        icache_addr_u a;
        int           w;
        a.raw = addr;
        w     = way;
        if (w < 0) begin
            w = model_lru[a.fields.index];   // victim
            model_tag[w][a.fields.index]   = a.fields.tag;
            model_valid[w][a.fields.index] = 1'b1;
        end
        model_lru[a.fields.index] = (w == 0);
    endtask

    // returns at the falling edge after the accepting edge
    task automatic wait_accept(input string name, output logic ok);
        int n;
        n = 0;
        #1;
        while (!resp.addr_ok && n < wait_limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        ok = resp.addr_ok;
        if (!ok) begin
            $display("timeout: %s request was never accepted", name);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic fetch(input string name, input logic [31:0] addr, output logic missed);
        int   way;
        int   n;
        logic ok;
        logic saw_req;
        way          = model_way(addr);
        req.valid    = 1'b1;
        req.addr.raw = addr;
        wait_accept(name, ok);
        req.valid = 1'b0;
        missed    = resp.cache_miss;   // lookup cycle
        check({name, " cache_miss"}, (way < 0), resp.cache_miss);
        n       = 1;
        saw_req = 1'b0;
        while (!resp.data_ok && n < wait_limit) begin
            if (mem_req.rd_req) begin
                saw_req = 1'b1;
                check({name, " rd_addr"}, {addr[31:4], 4'h0}, mem_req.rd_addr);
                check({name, " rd_type"}, 3'b100, mem_req.rd_type);
            end
            @(negedge clk);
            n++;
        end
        if (!resp.data_ok) begin
            $display("timeout: no answer for %s fetch of address %h", name, addr);
            errors++;
        end else begin
            check({name, " rdata"}, mem_word(addr), resp.rdata);
            if (way >= 0) begin
                check({name, " hit latency"}, 2, n);
                check({name, " rd_req on hit"}, 0, saw_req);
            end
        end
        model_update(addr, way);
    endtask

    task automatic after_reset();
        check("reset idle", 1, status.idle);
        check("reset last_hit", 0, status.last_hit);
        check("reset data_ok", 0, resp.data_ok);
        check("reset rd_req", 0, mem_req.rd_req);
    endtask

    task automatic cold_miss();
        logic missed;
        fetch("cold_miss", 32'h0001_2348, missed);
        check("cold_miss missed", 1, missed);
    endtask

    task automatic hit_after_fill();
        logic [31:0] addrs [3];
        logic        missed;
        int          i;
        addrs = '{32'h0001_2340, 32'h0001_2344, 32'h0001_234c};   // rest of the cold line
        for (i = 0; i < 3; i++) begin
            fetch("hit_after_fill", addrs[i], missed);
            check("hit_after_fill missed", 0, missed);
            check("hit_after_fill last_hit", 1, status.last_hit);
        end
    endtask

    task automatic two_way_lru();
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] seq [7];
        logic        exp_miss [7];
        logic        missed;
        int          i;
        a1 = {20'h00100, 8'h77, 4'h4};
        a2 = {20'h00200, 8'h77, 4'h8};
        a3 = {20'h00300, 8'h77, 4'h0};
        // a3 evicts a1, so a2 stays and a1 comes back as a miss
        seq      = '{a1, a2, a1, a2, a3, a2, a1};
        exp_miss = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
        for (i = 0; i < 7; i++) begin
            fetch("lru", seq[i], missed);
            check("lru missed", exp_miss[i], missed);
        end
    endtask

    task automatic back_to_back_hits();
        logic [31:0] base;
        logic [31:0] addrs [4];
        logic [31:0] pending [$];
        logic        missed;
        int          k;
        base = 32'h00ab_c550;
        fetch("back_to_back fill", base, missed);
        @(negedge clk);   // let the fill answer pass
        addrs = '{base + 8, base, base + 12, base + 4};
        for (k = 0; k <= 5; k++) begin
            check("back_to_back data_ok", (k >= 2), resp.data_ok);
            if (resp.data_ok && pending.size() > 0)
                check("back_to_back rdata", mem_word(pending.pop_front()), resp.rdata);
            if (k < 4) begin
                req.valid    = 1'b1;
                req.addr.raw = addrs[k];
                pending.push_back(addrs[k]);
                #1;
                check("back_to_back addr_ok", 1, resp.addr_ok);
                model_update(addrs[k], model_way(addrs[k]));
            end else begin
                req.valid = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    task automatic random_delays();
        logic [31:0] addr;
        logic        missed;
        int          i;
        for (i = 0; i < 40; i++) begin
            addr[31:12] = 20'h00a00 + 20'($urandom_range(3, 0));   // four tags
            addr[11:4]  = 8'h40 + 8'($urandom_range(2, 0));        // three sets
            addr[3:2]   = 2'($urandom_range(3, 0));
            addr[1:0]   = 2'b00;
            fetch("random", addr, missed);
        end
    endtask

    initial begin
        void'($urandom(32'h5d9eb2cd));
        req   = '0;
        reset = 1'b1;
        clear_model();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        after_reset();
        cold_miss();
        hit_after_fill();
        two_way_lru();
        back_to_back_hits();
        random_delays();
        $display("errors: %0d", errors);
        finished = 1'b1;
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // run stopped before the closing line
    final begin
        if (!finished)
            $display("SOME TESTS FAILED");
    end

endmodule

//--- files.f
src/icache_pkg.sv
src/icache_way.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/icache_asserts.sv
testbench/icache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f files.f -o icache_sim
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
